/* rtl/rv32_lite_alu.sv */
// Arithmetic and logic unit

`timescale 1ns/1ps
`default_nettype none

module rv32_lite_alu (
  input  rv32_lite_pkg::alu_op_e  op_i,
  input  rv32_lite_pkg::word_t    operand_a_i,
  input  rv32_lite_pkg::word_t    operand_b_i,
  output rv32_lite_pkg::word_t    result_o,
  output logic                    equal_o
);

  import rv32_lite_pkg::*;

  word_t sum;
  word_t diff;
  logic  less_than;

  assign sum  = operand_a_i + operand_b_i;
  assign diff = operand_a_i - operand_b_i;

  // Signed compare for SLT and SLTI
  assign less_than = $signed(operand_a_i) < $signed(operand_b_i);

  always_comb begin
    result_o = '0;
    case (op_i)
      ALU_ADD:    result_o = sum;
      ALU_SUB:    result_o = diff;
      ALU_AND:    result_o = operand_a_i & operand_b_i;
      ALU_OR:     result_o = operand_a_i | operand_b_i;
      ALU_XOR:    result_o = operand_a_i ^ operand_b_i;
      ALU_SLT:    result_o[0] = less_than;
      // LUI immediate goes straight through
      ALU_PASS_B: result_o = operand_b_i;
      default:    result_o = sum;
    endcase
  end

  // Branch condition, independent of op_i
  assign equal_o = (operand_a_i == operand_b_i);

endmodule

`default_nettype wire

/* rtl/rv32_lite_controller.sv */
// Multicycle control FSM

`timescale 1ns/1ps
`default_nettype none

module rv32_lite_controller (
  input  logic clk,
  input  logic rst_ni,
  input  logic fetch_enable_i,
  input  logic instr_valid_i,
  input  logic reg_write_i,
  input  logic is_load_i,
  input  logic is_store_i,
  input  logic is_branch_i,
  input  logic branch_ne_i,
  input  logic is_jump_i,
  input  logic illegal_i,
  input  logic equal_i,
  input  logic lsu_done_i,
  output logic fetch_req_o,
  output logic rf_we_o,
  output logic lsu_req_o,
  output logic pc_advance_o,
  output logic pc_jump_o,
  output logic halted_o
);

  import rv32_lite_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        fetch_req_q;
  logic        branch_taken;

  assign branch_taken = is_branch_i && (equal_i ^ branch_ne_i);

  always_comb begin
    state_d      = state_q;
    rf_we_o      = 1'b0;
    lsu_req_o    = 1'b0;
    pc_advance_o = 1'b0;
    pc_jump_o    = 1'b0;
    case (state_q)
      ST_IDLE:  if (fetch_enable_i) state_d = ST_FETCH;
      ST_FETCH: if (instr_valid_i) state_d = ST_EXEC;
      ST_EXEC: begin
        if (illegal_i) begin
          state_d = ST_HALT;
        end else if (is_load_i || is_store_i) begin
          lsu_req_o = 1'b1;
          state_d   = ST_MEM;
        end else begin
          // Retire in a single cycle
          rf_we_o      = reg_write_i;
          pc_advance_o = 1'b1;
          pc_jump_o    = is_jump_i || branch_taken;
          state_d      = ST_FETCH;
        end
      end
      ST_MEM: begin
        if (lsu_done_i) begin
          rf_we_o      = is_load_i && reg_write_i;
          pc_advance_o = 1'b1;
          state_d      = ST_FETCH;
        end
      end
      default: state_d = ST_HALT;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ST_IDLE;
      fetch_req_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      // One pulse on every entry into ST_FETCH
      fetch_req_q <= (state_d == ST_FETCH) && (state_q != ST_FETCH);
    end
  end

  assign fetch_req_o = fetch_req_q;
  assign halted_o    = (state_q == ST_HALT);

  // Fetch and LSU answer only in the state that waits for them
  a_fetch_resp : assert property (
    @(posedge clk) disable iff (!rst_ni) instr_valid_i |-> state_q == ST_FETCH);

  a_lsu_resp : assert property (
    @(posedge clk) disable iff (!rst_ni) lsu_done_i |-> state_q == ST_MEM);

endmodule

`default_nettype wire

/* rtl/rv32_lite_core.sv */
// RV32 lite core top level

`timescale 1ns/1ps
`default_nettype none

module rv32_lite_core (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  fetch_enable_i,
  output logic                  halted_o,
  // Instruction port
  output logic                  instr_req_o,
  output rv32_lite_pkg::word_t  instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  rv32_lite_pkg::word_t  instr_rdata_i,
  // Data port
  output logic                  data_req_o,
  output logic                  data_we_o,
  output rv32_lite_pkg::word_t  data_addr_o,
  output rv32_lite_pkg::word_t  data_wdata_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  rv32_lite_pkg::word_t  data_rdata_i
);

  import rv32_lite_pkg::*;

  logic      fetch_req, instr_valid, pc_advance, pc_jump;
  logic      rf_we, lsu_req, lsu_done, equal;
  logic      use_imm, reg_write, is_load, is_store;
  logic      is_branch, branch_ne, is_jump, illegal;
  word_t     instr, instr_q, pc, imm;
  word_t     rs1_data, rs2_data, operand_b, alu_result, lsu_rdata, wb_data;
  reg_addr_t rs1, rs2, rd;
  alu_op_e   alu_op;
  wb_sel_e   wb_sel;

  ////////////////////////////////////////
  // Fetch and instruction register
  ////////////////////////////////////////

  rv32_lite_fetch fetch0 (
    .clk, .rst_ni,
    .fetch_req_i(fetch_req), .pc_advance_i(pc_advance), .pc_jump_i(pc_jump),
    .offset_i(imm),
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i,
    .instr_valid_o(instr_valid), .instr_o(instr), .pc_o(pc)
  );

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      instr_q <= instr;
    end
  end

  rv32_lite_decoder decoder0 (
    .instr_i(instr_q), .alu_op_o(alu_op), .use_imm_o(use_imm), .imm_o(imm),
    .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd), .wb_sel_o(wb_sel), .reg_write_o(reg_write),
    .is_load_o(is_load), .is_store_o(is_store), .is_branch_o(is_branch),
    .branch_ne_o(branch_ne), .is_jump_o(is_jump), .illegal_o(illegal)
  );

  ////////////////////////////////////////
  // Execute and writeback
  ////////////////////////////////////////

  rv32_lite_regfile regfile0 (
    .clk, .rst_ni,
    .raddr_a_i(rs1), .raddr_b_i(rs2), .rdata_a_o(rs1_data), .rdata_b_o(rs2_data),
    .we_i(rf_we), .waddr_i(rd), .wdata_i(wb_data)
  );

  assign operand_b = use_imm ? imm : rs2_data;

  rv32_lite_alu alu0 (
    .op_i(alu_op), .operand_a_i(rs1_data), .operand_b_i(operand_b),
    .result_o(alu_result), .equal_o(equal)
  );

  always_comb begin
    case (wb_sel)
      WB_LOAD: wb_data = lsu_rdata;
      WB_PC4:  wb_data = pc + word_t'(4);
      default: wb_data = alu_result;
    endcase
  end

  rv32_lite_lsu lsu0 (
    .clk, .rst_ni,
    .lsu_req_i(lsu_req), .we_i(is_store), .addr_i(alu_result), .wdata_i(rs2_data),
    .data_req_o, .data_we_o, .data_addr_o, .data_wdata_o,
    .data_gnt_i, .data_rvalid_i, .data_rdata_i,
    .lsu_done_o(lsu_done), .rdata_o(lsu_rdata)
  );

  rv32_lite_controller controller0 (
    .clk, .rst_ni, .fetch_enable_i,
    .instr_valid_i(instr_valid), .reg_write_i(reg_write), .is_load_i(is_load),
    .is_store_i(is_store), .is_branch_i(is_branch), .branch_ne_i(branch_ne),
    .is_jump_i(is_jump), .illegal_i(illegal), .equal_i(equal), .lsu_done_i(lsu_done),
    .fetch_req_o(fetch_req), .rf_we_o(rf_we), .lsu_req_o(lsu_req),
    .pc_advance_o(pc_advance), .pc_jump_o(pc_jump), .halted_o
  );

endmodule

`default_nettype wire

/* rtl/rv32_lite_decoder.sv */
// Instruction decoder

`timescale 1ns/1ps
`default_nettype none

module rv32_lite_decoder (
  input  rv32_lite_pkg::word_t      instr_i,
  output rv32_lite_pkg::alu_op_e    alu_op_o,
  output logic                      use_imm_o,
  output rv32_lite_pkg::word_t      imm_o,
  output rv32_lite_pkg::reg_addr_t  rs1_o,
  output rv32_lite_pkg::reg_addr_t  rs2_o,
  output rv32_lite_pkg::reg_addr_t  rd_o,
  output rv32_lite_pkg::wb_sel_e    wb_sel_o,
  output logic                      reg_write_o,
  output logic                      is_load_o,
  output logic                      is_store_o,
  output logic                      is_branch_o,
  output logic                      branch_ne_o,
  output logic                      is_jump_o,
  output logic                      illegal_o
);

  import rv32_lite_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i_type;
  word_t      imm_s_type;
  word_t      imm_b_type;
  word_t      imm_u_type;
  word_t      imm_j_type;

  assign opcode = opcode_e'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  assign rd_o  = instr_i[11:7];
  assign rs1_o = instr_i[19:15];
  assign rs2_o = instr_i[24:20];

  ////////////////////////////////////////
  // Immediates
  ////////////////////////////////////////

  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};
  assign imm_j_type = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                       instr_i[30:21], 1'b0};

  ////////////////////////////////////////
  // Control decode
  ////////////////////////////////////////

  always_comb begin
    alu_op_o    = ALU_ADD;
    use_imm_o   = 1'b0;
    imm_o       = imm_i_type;
    wb_sel_o    = WB_ALU;
    reg_write_o = 1'b0;
    is_load_o   = 1'b0;
    is_store_o  = 1'b0;
    is_branch_o = 1'b0;
    branch_ne_o = 1'b0;
    is_jump_o   = 1'b0;
    illegal_o   = 1'b0;

    case (opcode)
      OP_IMM: begin
        use_imm_o   = 1'b1;
        reg_write_o = 1'b1;
        case (funct3)
          3'b000:  alu_op_o = ALU_ADD;
          3'b010:  alu_op_o = ALU_SLT;
          3'b100:  alu_op_o = ALU_XOR;
          3'b110:  alu_op_o = ALU_OR;
          3'b111:  alu_op_o = ALU_AND;
          default: illegal_o = 1'b1;
        endcase
      end
      OP_REG: begin
        reg_write_o = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op_o = ALU_ADD;
          {7'h20, 3'b000}: alu_op_o = ALU_SUB;
          {7'h00, 3'b010}: alu_op_o = ALU_SLT;
          {7'h00, 3'b100}: alu_op_o = ALU_XOR;
          {7'h00, 3'b110}: alu_op_o = ALU_OR;
          {7'h00, 3'b111}: alu_op_o = ALU_AND;
          default:         illegal_o = 1'b1;
        endcase
      end
      OP_LUI: begin
        alu_op_o    = ALU_PASS_B;
        use_imm_o   = 1'b1;
        imm_o       = imm_u_type;
        reg_write_o = 1'b1;
      end
      OP_LOAD: begin
        use_imm_o   = 1'b1;
        is_load_o   = 1'b1;
        reg_write_o = 1'b1;
        wb_sel_o    = WB_LOAD;
        illegal_o   = (funct3 != 3'b010);
      end
      OP_STORE: begin
        use_imm_o  = 1'b1;
        imm_o      = imm_s_type;
        is_store_o = 1'b1;
        illegal_o  = (funct3 != 3'b010);
      end
      OP_BRANCH: begin
        // ALU compares rs1 against rs2
        imm_o       = imm_b_type;
        is_branch_o = 1'b1;
        branch_ne_o = funct3[0];
        illegal_o   = (funct3[2:1] != 2'b00);
      end
      OP_JAL: begin
        imm_o       = imm_j_type;
        is_jump_o   = 1'b1;
        reg_write_o = 1'b1;
        wb_sel_o    = WB_PC4;
      end
      default: illegal_o = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/rv32_lite_defs.svh */
// RV32 lite core parameters

`ifndef RV32_LITE_DEFS_SVH
`define RV32_LITE_DEFS_SVH

// Data and address width
`define RV_XLEN 32

// Register file geometry
`define RV_NUM_REGS 32
`define RV_REG_AW 5

// First fetch address after reset
`define RV_BOOT_ADDR 32'h0000_0000

`endif

/* rtl/rv32_lite_fetch.sv */
// Instruction fetch unit

`timescale 1ns/1ps
`default_nettype none

`include "rv32_lite_defs.svh"

module rv32_lite_fetch (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  fetch_req_i,
  input  logic                  pc_advance_i,
  input  logic                  pc_jump_i,
  input  rv32_lite_pkg::word_t  offset_i,
  output logic                  instr_req_o,
  output rv32_lite_pkg::word_t  instr_addr_o,
  input  logic                  instr_gnt_i,
  input  logic                  instr_rvalid_i,
  input  rv32_lite_pkg::word_t  instr_rdata_i,
  output logic                  instr_valid_o,
  output rv32_lite_pkg::word_t  instr_o,
  output rv32_lite_pkg::word_t  pc_o
);

  import rv32_lite_pkg::*;

  typedef enum logic [1:0] {
    F_IDLE,
    F_REQ,
    F_WAIT
  } fetch_state_e;

  fetch_state_e state_q;
  word_t        pc_q;

  // Bus master phases
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= F_IDLE;
    end else begin
      case (state_q)
        F_IDLE:  if (fetch_req_i) state_q <= F_REQ;
        F_REQ:   if (instr_gnt_i) state_q <= F_WAIT;
        F_WAIT:  if (instr_rvalid_i) state_q <= F_IDLE;
        default: state_q <= F_IDLE;
      endcase
    end
  end

  // Next PC is sequential or the branch/jump target
  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pc_q <= `RV_BOOT_ADDR;
    end else if (pc_advance_i) begin
      pc_q <= pc_jump_i ? pc_q + offset_i : pc_q + word_t'(4);
    end
  end

  assign instr_req_o   = (state_q == F_REQ);
  assign instr_addr_o  = pc_q;
  assign instr_valid_o = (state_q == F_WAIT) && instr_rvalid_i;
  assign instr_o       = instr_rdata_i;
  assign pc_o          = pc_q;

  // Controller only asks for a fetch when none is outstanding
  a_fetch_req_idle : assert property (
    @(posedge clk) disable iff (!rst_ni) fetch_req_i |-> state_q == F_IDLE);

endmodule

`default_nettype wire

/* rtl/rv32_lite_lsu.sv */
// Word load/store unit

`timescale 1ns/1ps
`default_nettype none

module rv32_lite_lsu (
  input  logic                  clk,
  input  logic                  rst_ni,
  input  logic                  lsu_req_i,
  input  logic                  we_i,
  input  rv32_lite_pkg::word_t  addr_i,
  input  rv32_lite_pkg::word_t  wdata_i,
  output logic                  data_req_o,
  output logic                  data_we_o,
  output rv32_lite_pkg::word_t  data_addr_o,
  output rv32_lite_pkg::word_t  data_wdata_o,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  input  rv32_lite_pkg::word_t  data_rdata_i,
  output logic                  lsu_done_o,
  output rv32_lite_pkg::word_t  rdata_o
);

  import rv32_lite_pkg::*;

  typedef enum logic [1:0] {
    L_IDLE,
    L_REQ,
    L_WAIT
  } lsu_state_e;

  lsu_state_e state_q;
  logic       we_q;
  logic       done_q;
  word_t      addr_q;
  word_t      wdata_q;
  word_t      rdata_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= L_IDLE;
      we_q    <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        L_IDLE: begin
          if (lsu_req_i) begin
            state_q <= L_REQ;
            we_q    <= we_i;
          end
        end
        L_REQ: if (data_gnt_i) state_q <= L_WAIT;
        L_WAIT: begin
          if (data_rvalid_i) begin
            state_q <= L_IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= L_IDLE;
      endcase
    end
  end

  // Request payload and read data
  always_ff @(posedge clk) begin
    if ((state_q == L_IDLE) && lsu_req_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if ((state_q == L_WAIT) && data_rvalid_i) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign data_req_o   = (state_q == L_REQ);
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;
  assign lsu_done_o   = done_q;
  assign rdata_o      = rdata_q;

  // A new request only arrives while the bus is idle
  a_req_idle : assert property (
    @(posedge clk) disable iff (!rst_ni) lsu_req_i |-> state_q == L_IDLE);

endmodule

`default_nettype wire

/* rtl/rv32_lite_pkg.sv */
// RV32 lite shared types

`default_nettype none

`include "rv32_lite_defs.svh"

package rv32_lite_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_REG_AW-1:0] reg_addr_t;

  // Major opcodes of the kept RV32I subset
  typedef enum logic [6:0] {
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  // Register writeback source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4
  } wb_sel_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_EXEC,
    ST_MEM,
    ST_HALT
  } ctrl_state_e;

endpackage

`default_nettype wire

/* rtl/rv32_lite_regfile.sv */
// Integer register file

`timescale 1ns/1ps
`default_nettype none

`include "rv32_lite_defs.svh"

module rv32_lite_regfile (
  input  logic                      clk,
  input  logic                      rst_ni,
  input  rv32_lite_pkg::reg_addr_t  raddr_a_i,
  input  rv32_lite_pkg::reg_addr_t  raddr_b_i,
  output rv32_lite_pkg::word_t      rdata_a_o,
  output rv32_lite_pkg::word_t      rdata_b_o,
  input  logic                      we_i,
  input  rv32_lite_pkg::reg_addr_t  waddr_i,
  input  rv32_lite_pkg::word_t      wdata_i
);

  import rv32_lite_pkg::*;

  // No storage for x0
  word_t regs_q [1:`RV_NUM_REGS-1];

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

/* rv32_lite.f */
+incdir+rtl
rtl/rv32_lite_pkg.sv
rtl/rv32_lite_fetch.sv
rtl/rv32_lite_decoder.sv
rtl/rv32_lite_regfile.sv
rtl/rv32_lite_alu.sv
rtl/rv32_lite_lsu.sv
rtl/rv32_lite_controller.sv
rtl/rv32_lite_core.sv
test/rv32_lite_tb_mem.sv
test/rv32_lite_tb.sv

/* test/rv32_lite_tb.sv */
// RV32 lite core testbench

`timescale 1ns/1ps
`default_nettype none

`include "rv32_lite_defs.svh"

module rv32_lite_tb;

  import rv32_lite_pkg::*;

  localparam int PROG_LEN   = 43;
  localparam int NUM_STORES = 15;
  localparam int MAX_CYCLES = PROG_LEN * 20;

  logic        clk;
  logic        rst_ni;
  logic        fetch_enable;
  logic        halted;
  logic        instr_req;
  word_t       instr_addr;
  logic        instr_gnt;
  logic        instr_rvalid;
  word_t       instr_rdata;
  logic        data_req;
  logic        data_we;
  word_t       data_addr;
  word_t       data_wdata;
  logic        data_gnt;
  logic        data_rvalid;
  word_t       data_rdata;
  int unsigned cycles = 0;

  ////////////////////////////////////////
  // Program and expected stores
  ////////////////////////////////////////

  // x10 holds the store base 0x200, x11 the load base 0x100
  word_t prog_rom [PROG_LEN] = '{
    32'h0060_0093, 32'hffd0_0113, 32'h2000_0513,  // addi x1=6, x2=-3, x10=0x200
    32'h0020_81b3, 32'h0035_2023,                 // add x3; sw 0x200
    32'h4011_0233, 32'h0045_2223,                 // sub x4=x2-x1; sw 0x204
    32'h0020_f2b3, 32'h0055_2423,                 // and; sw 0x208
    32'h0020_e2b3, 32'h0055_2623,                 // or; sw 0x20c
    32'h0020_c2b3, 32'h0055_2823,                 // xor; sw 0x210
    32'h0020_a2b3, 32'h0055_2a23,                 // slt x1<x2; sw 0x214
    32'hffe1_2293, 32'h0055_2c23,                 // slti x2<-2; sw 0x218
    32'h1234_52b7, 32'h6782_e293, 32'h0055_2e23,  // lui; ori 0x678; sw 0x21c
    32'hfff2_c313, 32'h7f03_7313, 32'h0265_2023,  // xori -1; andi 0x7f0; sw 0x220
    32'h0070_8013, 32'h0205_2223,                 // addi x0; sw x0 at 0x224
    32'h1000_0593, 32'h0005_a383, 32'h0045_a403,  // x11=0x100; lw x7; lw x8
    32'h0083_84b3, 32'h0275_2423, 32'h0295_2623,  // add x9; sw x7; sw x9
    32'h0010_8463, 32'h0215_2e23,                 // beq taken; skipped store
    32'h0020_9463, 32'h0215_2e23,                 // bne taken; skipped store
    32'h0020_8463, 32'h0215_2823,                 // beq not taken; sw x1 0x230
    32'h0010_9463, 32'h0225_2a23,                 // bne not taken; sw x2 0x234
    32'h0080_066f, 32'h0215_2e23, 32'h02c5_2c23,  // jal x12; skipped; sw x12
    32'hffff_ffff                                 // illegal
  };

  // Address in the upper word, data in the lower
  logic [63:0] store_tab [NUM_STORES] = '{
    {32'h0000_0200, 32'h0000_0003}, {32'h0000_0204, 32'hffff_fff7},
    {32'h0000_0208, 32'h0000_0004}, {32'h0000_020c, 32'hffff_ffff},
    {32'h0000_0210, 32'hffff_fffb}, {32'h0000_0214, 32'h0000_0000},
    {32'h0000_0218, 32'h0000_0001}, {32'h0000_021c, 32'h1234_5678},
    {32'h0000_0220, 32'h0000_0180}, {32'h0000_0224, 32'h0000_0000},
    {32'h0000_0228, 32'h1357_9bdf}, {32'h0000_022c, 32'h159e_26ad},
    {32'h0000_0230, 32'h0000_0006}, {32'h0000_0234, 32'hffff_fffd},
    {32'h0000_0238, 32'h0000_00a0}
  };

  rv32_lite_core dut0 (
    .clk, .rst_ni, .fetch_enable_i(fetch_enable), .halted_o(halted),
    .instr_req_o(instr_req), .instr_addr_o(instr_addr), .instr_gnt_i(instr_gnt),
    .instr_rvalid_i(instr_rvalid), .instr_rdata_i(instr_rdata),
    .data_req_o(data_req), .data_we_o(data_we), .data_addr_o(data_addr),
    .data_wdata_o(data_wdata), .data_gnt_i(data_gnt), .data_rvalid_i(data_rvalid),
    .data_rdata_i(data_rdata)
  );

  rv32_lite_tb_mem mem0 (
    .clk, .instr_req_i(instr_req), .instr_addr_i(instr_addr), .instr_gnt_o(instr_gnt),
    .instr_rvalid_o(instr_rvalid), .instr_rdata_o(instr_rdata),
    .data_req_i(data_req), .data_we_i(data_we), .data_addr_i(data_addr),
    .data_wdata_i(data_wdata), .data_gnt_o(data_gnt), .data_rvalid_o(data_rvalid),
    .data_rdata_o(data_rdata)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      fail_run($sformatf("Timeout: the core did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic compare_word(input string name, input word_t expected, input word_t actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error: %s expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      fail_run($sformatf("** Error: %s expected %b, actual %b", name, expected, actual));
    end
  endtask

  task automatic load_memories();
    for (int i = 0; i < PROG_LEN; i++) begin
      mem0.imem[i] = prog_rom[i];
    end
    // Load operands at 0x100 and 0x104
    mem0.dmem[64] = 32'h1357_9bdf;
    mem0.dmem[65] = 32'h0246_8ace;
  endtask

  // Next granted write, seen in the cycle before its grant edge
  task automatic wait_store(input int idx, output word_t addr, output word_t wdata);
    do begin
      @(negedge clk);
      if (halted) begin
        fail_run($sformatf("Core halted before store %0d was seen", idx));
      end
    end while (!(data_req && data_we && data_gnt));
    addr  = data_addr;
    wdata = data_wdata;
  endtask

  ////////////////////////////////////////
  // Run sequence
  ////////////////////////////////////////

  initial begin
    word_t got_addr;
    word_t got_data;
    clk          = 1'b0;
    rst_ni       = 1'b0;
    fetch_enable = 1'b0;
    #1;
    load_memories();
    repeat (3) @(posedge clk);
    #1 rst_ni = 1'b1;

    // Idle until enabled
    repeat (10) begin
      @(negedge clk);
      compare_bit("idle instr_req", 1'b0, instr_req);
      compare_bit("idle halted", 1'b0, halted);
    end
    @(posedge clk);
    #1 fetch_enable = 1'b1;
    do @(negedge clk); while (!instr_req);
    compare_word("boot fetch address", `RV_BOOT_ADDR, instr_addr);

    for (int i = 0; i < NUM_STORES; i++) begin
      wait_store(i, got_addr, got_data);
      compare_word($sformatf("store %0d address", i), store_tab[i][63:32], got_addr);
      compare_word($sformatf("store %0d data", i), store_tab[i][31:0], got_data);
    end

    // Illegal word ends the program
    while (!halted) begin
      @(negedge clk);
      if (data_req) begin
        fail_run("Data access after the last expected store");
      end
    end
    repeat (20) begin
      @(negedge clk);
      compare_bit("halted stays high", 1'b1, halted);
      compare_bit("no fetch after halt", 1'b0, instr_req);
      compare_bit("no data access after halt", 1'b0, data_req);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* test/rv32_lite_tb_mem.sv */
// Instruction and data memory model

`timescale 1ns/1ps
`default_nettype none

module rv32_lite_tb_mem (
  input  logic                  clk,
  input  logic                  instr_req_i,
  input  rv32_lite_pkg::word_t  instr_addr_i,
  output logic                  instr_gnt_o,
  output logic                  instr_rvalid_o,
  output rv32_lite_pkg::word_t  instr_rdata_o,
  input  logic                  data_req_i,
  input  logic                  data_we_i,
  input  rv32_lite_pkg::word_t  data_addr_i,
  input  rv32_lite_pkg::word_t  data_wdata_i,
  output logic                  data_gnt_o,
  output logic                  data_rvalid_o,
  output rv32_lite_pkg::word_t  data_rdata_o
);

  import rv32_lite_pkg::*;

  word_t       imem [256];
  word_t       dmem [256];
  logic [31:0] lfsr;
  logic        i_pend;
  logic        d_pend;
  logic        i_accept;
  logic        d_accept;
  int unsigned i_gnt_wait;
  int unsigned i_rv_wait;
  int unsigned d_gnt_wait;
  int unsigned d_rv_wait;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two LFSR bits give a wait of 0 to 3 cycles
  task automatic draw_delay(output int unsigned d);
    d = 0;
    repeat (2) begin
      lfsr = lfsr_next(lfsr);
      d    = (d << 1) | lfsr[0];
    end
  endtask

  // One cycle of the req/gnt/rvalid slave on a single port
  task automatic step_port(input logic req, output logic accept, inout logic gnt,
                           inout logic rvalid, inout logic pend,
                           inout int unsigned gnt_wait, inout int unsigned rv_wait);
    accept = 1'b0;
    rvalid = 1'b0;
    if (gnt) begin
      // Grant was taken at this edge
      gnt  = 1'b0;
      pend = 1'b1;
      draw_delay(rv_wait);
    end
    if (pend) begin
      if (rv_wait == 0) begin
        rvalid = 1'b1;
        pend   = 1'b0;
      end else begin
        rv_wait--;
      end
    end else if (req) begin
      if (gnt_wait == 0) begin
        gnt    = 1'b1;
        accept = 1'b1;
        draw_delay(gnt_wait);
      end else begin
        gnt_wait--;
      end
    end
  endtask

  initial begin
    lfsr           = 32'h368c_e999;
    instr_gnt_o    = 1'b0;
    instr_rvalid_o = 1'b0;
    instr_rdata_o  = '0;
    data_gnt_o     = 1'b0;
    data_rvalid_o  = 1'b0;
    data_rdata_o   = '0;
    i_pend         = 1'b0;
    d_pend         = 1'b0;
    i_gnt_wait     = 0;
    d_gnt_wait     = 0;
    i_rv_wait      = 0;
    d_rv_wait      = 0;
    for (int i = 0; i < 256; i++) begin
      // Empty code reads as an illegal all-zero word
      imem[i] = '0;
      dmem[i] = 32'hc0de_0000 | word_t'(i * 4);
    end
  end

  // Responses change just after the rising edge
  always @(posedge clk) begin
    #1;
    step_port(instr_req_i, i_accept, instr_gnt_o, instr_rvalid_o, i_pend,
              i_gnt_wait, i_rv_wait);
    if (i_accept) begin
      instr_rdata_o = imem[instr_addr_i[9:2]];
    end
    step_port(data_req_i, d_accept, data_gnt_o, data_rvalid_o, d_pend,
              d_gnt_wait, d_rv_wait);
    if (d_accept) begin
      if (data_we_i) begin
        dmem[data_addr_i[9:2]] = data_wdata_i;
      end
      data_rdata_o = dmem[data_addr_i[9:2]];
    end
  end

endmodule

`default_nettype wire
